// File: Makefile
# Verilator build and run for the instruction cache testbench

TOP := instrCacheTb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f

# Pass only when the simulation output holds the pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir

// File: design/icacheController.sv
// ##########################################################
// Instruction cache controller, second pipeline stage
// Hit check, line refill, uncached fetch and response
// ##########################################################

module icacheController (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  enable,

    // Held request from the first stage
    input  logic                  heldValid,
    input  icachePkg::wordT       heldAddr,
    input  icachePkg::tagT        heldTag,
    output logic                  releaseHeld,

    // Array read side
    input  logic                  way0Valid,
    input  logic                  way1Valid,
    input  icachePkg::tagT        way0Tag,
    input  icachePkg::tagT        way1Tag,
    input  icachePkg::wordT       way0Data,
    input  icachePkg::wordT       way1Data,
    input  logic                  lruWay,

    // Array addressing and update
    output icachePkg::setIndexT   readSet,
    output icachePkg::wordOffsetT readOffset,
    output logic                  writeEnable,
    output logic                  writeWay,
    output icachePkg::wordOffsetT writeOffset,
    output icachePkg::wordT       writeData,
    output logic                  markValid,
    output icachePkg::tagT        fillTag,
    output logic                  touchEnable,
    output logic                  touchWay,

    // Word-wide bus
    output logic                  busRequest,
    output icachePkg::wordT       busAddr,
    input  icachePkg::wordT       busData,
    input  logic                  busReady,

    // Response
    output logic                  rspValid,
    input  logic                  rspReady,
    output icachePkg::wordT       rspData
);

    icachePkg::ctrlStateT  state;
    icachePkg::ctrlStateT  nextState;
    icachePkg::wordOffsetT refillCount;
    icachePkg::wordT       bypassData;
    logic                  bypassFull;
    logic                  victimWay;
    logic                  missWay;
    logic                  hit0;
    logic                  hit1;
    logic                  lookupHit;
    logic                  busTake;
    logic                  lastWord;

    // Set and offset come from the virtual address
    assign readSet    = heldAddr[icachePkg::ByteBits+icachePkg::OffsetBits +: icachePkg::SetBits];
    assign readOffset = heldAddr[icachePkg::ByteBits +: icachePkg::OffsetBits];

    assign hit0 = way0Valid && (way0Tag == heldTag);
    assign hit1 = way1Valid && (way1Tag == heldTag);

    // Empty way first, way 0 before way 1, then LRU
    always_comb begin
        if (!way0Valid) begin
            missWay = 1'b0;
        end else if (!way1Valid) begin
            missWay = 1'b1;
        end else begin
            missWay = lruWay;
        end
    end

    assign lookupHit = (state == icachePkg::Lookup) && heldValid && enable && (hit0 || hit1);
    assign busTake   = busRequest && busReady;
    assign lastWord  = refillCount == icachePkg::wordOffsetT'(icachePkg::BlockWords - 1);

    // Bus side
    assign busRequest = (state == icachePkg::Refill) ||
                        ((state == icachePkg::Uncached) && !bypassFull);
    assign busAddr    = (state == icachePkg::Uncached) ?
                        {heldAddr[31:icachePkg::ByteBits], {icachePkg::ByteBits{1'b0}}} :
                        {heldTag, readSet, refillCount, {icachePkg::ByteBits{1'b0}}};

    // Refill words go straight to the victim way
    assign writeEnable = (state == icachePkg::Refill) && busReady;
    assign writeWay    = victimWay;
    assign writeOffset = refillCount;
    assign writeData   = busData;
    assign markValid   = state == icachePkg::Fill;
    assign fillTag     = heldTag;
    assign touchEnable = (state == icachePkg::Fill) || (lookupHit && rspReady);
    assign touchWay    = (state == icachePkg::Fill) ? victimWay : hit1;

    // Response from the hit way or from the bypass register
    assign rspValid    = lookupHit || ((state == icachePkg::Uncached) && bypassFull);
    assign rspData     = (state == icachePkg::Uncached) ? bypassData :
                         (hit1 ? way1Data : way0Data);
    assign releaseHeld = rspValid && rspReady;

    always_comb begin
        nextState = state;
        case (state)
            icachePkg::Idle: begin
                nextState = icachePkg::Lookup;
            end
            icachePkg::Lookup: begin
                if (heldValid && !enable) begin
                    nextState = icachePkg::Uncached;
                end else if (heldValid && !(hit0 || hit1)) begin
                    nextState = icachePkg::Refill;
                end
            end
            icachePkg::Refill: begin
                if (busReady && lastWord) begin
                    nextState = icachePkg::Fill;
                end
            end
            icachePkg::Fill: begin
                nextState = icachePkg::Lookup;
            end
            icachePkg::Uncached: begin
                if (releaseHeld) begin
                    nextState = icachePkg::Lookup;
                end
            end
            default: begin
                nextState = icachePkg::Idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= icachePkg::Idle;
            refillCount <= '0;
            bypassFull  <= 1'b0;
        end else begin
            state <= nextState;
            if (writeEnable) begin
                refillCount <= refillCount + icachePkg::wordOffsetT'(1);
            end
            if ((state == icachePkg::Uncached) && busTake) begin
                bypassFull <= 1'b1;
            end else if ((state == icachePkg::Uncached) && releaseHeld) begin
                bypassFull <= 1'b0;
            end
        end
    end

    // Victim is fixed at lookup and kept through refill and fill
    always_ff @(posedge clk) begin
        if (state == icachePkg::Lookup) begin
            victimWay <= missWay;
        end
        if ((state == icachePkg::Uncached) && busTake) begin
            bypassData <= busData;
        end
    end

endmodule

// File: design/icachePkg.sv
// ##########################################################
// Instruction cache shared definitions
// Line geometry, vector types and controller states
// ##########################################################

package icachePkg;

    // Line and set geometry
    localparam int BlockWords = 4;
    localparam int SetCount   = 16;
    localparam int OffsetBits = $clog2(BlockWords);
    localparam int SetBits    = $clog2(SetCount);

    // Instructions are word aligned, so the low byte bits are always zero
    localparam int ByteBits = 2;

    // Physical tag is whatever remains above set and offset
    localparam int TagBits = 32 - ByteBits - OffsetBits - SetBits;

    // Instruction word or byte address
    typedef logic [31:0] wordT;

    // Physical tag from address translation
    typedef logic [TagBits-1:0] tagT;

    // Set index and word position within a line
    typedef logic [SetBits-1:0]    setIndexT;
    typedef logic [OffsetBits-1:0] wordOffsetT;

    // Second stage controller states
    typedef enum logic [2:0] {
        Idle,
        Lookup,
        Refill,
        Fill,
        Uncached
    } ctrlStateT;

endpackage

// File: design/icacheRequestStage.sv
// ##########################################################
// Instruction cache request stage
// Captures a fetch request and holds it until released
// ##########################################################

module icacheRequestStage (
    input  logic            clk,
    input  logic            reset,

    // Fetch request
    input  logic            reqValid,
    output logic            reqReady,
    input  icachePkg::wordT addr,
    input  icachePkg::tagT  physTag,

    // From the second stage, high when the response is taken
    input  logic            releaseHeld,

    // Held request toward the second stage
    output logic            heldValid,
    output icachePkg::wordT heldAddr,
    output icachePkg::tagT  heldTag
);

    logic accept;

    // Slot is free when empty or when its response leaves this cycle
    assign reqReady = !heldValid || releaseHeld;
    assign accept   = reqValid && reqReady;

    // Occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            heldValid <= 1'b0;
        end else if (accept) begin
            heldValid <= 1'b1;
        end else if (releaseHeld) begin
            heldValid <= 1'b0;
        end
    end

    // Request payload, loaded on every accepted transfer
    always_ff @(posedge clk) begin
        if (accept) begin
            heldAddr <= addr;
            heldTag  <= physTag;
        end
    end

endmodule

// File: design/icacheWayMemory.sv
// ##########################################################
// Instruction cache arrays for both ways
// Tags, valid bits, line data and one LRU bit per set
// ##########################################################

module icacheWayMemory (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  invalidate,

    // Read address, also the set for every write
    input  icachePkg::setIndexT   readSet,
    input  icachePkg::wordOffsetT readOffset,

    // Line fill
    input  logic                  writeEnable,
    input  logic                  writeWay,
    input  icachePkg::wordOffsetT writeOffset,
    input  icachePkg::wordT       writeData,
    input  logic                  markValid,
    input  icachePkg::tagT        fillTag,

    // Replacement update
    input  logic                  touchEnable,
    input  logic                  touchWay,

    // Combinational read of the selected set
    output logic                  way0Valid,
    output logic                  way1Valid,
    output icachePkg::tagT        way0Tag,
    output icachePkg::tagT        way1Tag,
    output icachePkg::wordT       way0Data,
    output icachePkg::wordT       way1Data,
    output logic                  lruWay
);

    // Data words indexed by {set, offset}
    icachePkg::wordT way0Words [icachePkg::SetCount * icachePkg::BlockWords];
    icachePkg::wordT way1Words [icachePkg::SetCount * icachePkg::BlockWords];

    icachePkg::tagT way0Tags [icachePkg::SetCount];
    icachePkg::tagT way1Tags [icachePkg::SetCount];

    logic [icachePkg::SetCount-1:0] way0ValidBits;
    logic [icachePkg::SetCount-1:0] way1ValidBits;

    // Bit set means way 1 is least recently used
    logic [icachePkg::SetCount-1:0] lruBits;

    logic [icachePkg::SetBits+icachePkg::OffsetBits-1:0] readIndex;
    logic [icachePkg::SetBits+icachePkg::OffsetBits-1:0] writeIndex;

    assign readIndex  = {readSet, readOffset};
    assign writeIndex = {readSet, writeOffset};

    // Line data and tags
    always_ff @(posedge clk) begin
        if (writeEnable) begin
            if (writeWay) begin
                way1Words[writeIndex] <= writeData;
            end else begin
                way0Words[writeIndex] <= writeData;
            end
        end
        if (markValid) begin
            if (writeWay) begin
                way1Tags[readSet] <= fillTag;
            end else begin
                way0Tags[readSet] <= fillTag;
            end
        end
    end

    // Valid and LRU state
    always_ff @(posedge clk) begin
        if (reset) begin
            way0ValidBits <= '0;
            way1ValidBits <= '0;
            lruBits       <= '0;
        end else begin
            if (invalidate) begin
                way0ValidBits <= '0;
                way1ValidBits <= '0;
            end else if (markValid) begin
                if (writeWay) begin
                    way1ValidBits[readSet] <= 1'b1;
                end else begin
                    way0ValidBits[readSet] <= 1'b1;
                end
            end
            // A touched way becomes most recently used
            if (touchEnable) begin
                lruBits[readSet] <= !touchWay;
            end
        end
    end

    assign way0Valid = way0ValidBits[readSet];
    assign way1Valid = way1ValidBits[readSet];
    assign way0Tag   = way0Tags[readSet];
    assign way1Tag   = way1Tags[readSet];
    assign way0Data  = way0Words[readIndex];
    assign way1Data  = way1Words[readIndex];
    assign lruWay    = lruBits[readSet];

endmodule

// File: design/instrCache.sv
// ##########################################################
// Two-way set-associative read-only instruction cache
// Request stage, controller stage and way arrays
// ##########################################################

module instrCache (
    input  logic            clk,
    input  logic            reset,

    // Fetch request
    input  logic            reqValid,
    output logic            reqReady,
    input  icachePkg::wordT addr,
    input  icachePkg::tagT  physTag,

    // Response
    output logic            rspValid,
    input  logic            rspReady,
    output icachePkg::wordT rspData,

    // Bus
    output logic            busRequest,
    output icachePkg::wordT busAddr,
    input  icachePkg::wordT busData,
    input  logic            busReady,

    // Control
    input  logic            enable,
    input  logic            invalidate
);

    // Stage to stage
    logic            heldValid;
    icachePkg::wordT heldAddr;
    icachePkg::tagT  heldTag;
    logic            releaseHeld;

    // Controller to arrays
    icachePkg::setIndexT   readSet;
    icachePkg::wordOffsetT readOffset;
    logic                  writeEnable;
    logic                  writeWay;
    icachePkg::wordOffsetT writeOffset;
    icachePkg::wordT       writeData;
    logic                  markValid;
    icachePkg::tagT        fillTag;
    logic                  touchEnable;
    logic                  touchWay;

    // Arrays to controller
    logic            way0Valid;
    logic            way1Valid;
    icachePkg::tagT  way0Tag;
    icachePkg::tagT  way1Tag;
    icachePkg::wordT way0Data;
    icachePkg::wordT way1Data;
    logic            lruWay;

    icacheRequestStage requestStage (
        .clk        (clk        ),
        .reset      (reset      ),
        .reqValid   (reqValid   ),
        .reqReady   (reqReady   ),
        .addr       (addr       ),
        .physTag    (physTag    ),
        .releaseHeld(releaseHeld),
        .heldValid  (heldValid  ),
        .heldAddr   (heldAddr   ),
        .heldTag    (heldTag    )
    );

    icacheController controller (
        .clk        (clk        ),
        .reset      (reset      ),
        .enable     (enable     ),
        .heldValid  (heldValid  ),
        .heldAddr   (heldAddr   ),
        .heldTag    (heldTag    ),
        .releaseHeld(releaseHeld),
        .way0Valid  (way0Valid  ),
        .way1Valid  (way1Valid  ),
        .way0Tag    (way0Tag    ),
        .way1Tag    (way1Tag    ),
        .way0Data   (way0Data   ),
        .way1Data   (way1Data   ),
        .lruWay     (lruWay     ),
        .readSet    (readSet    ),
        .readOffset (readOffset ),
        .writeEnable(writeEnable),
        .writeWay   (writeWay   ),
        .writeOffset(writeOffset),
        .writeData  (writeData  ),
        .markValid  (markValid  ),
        .fillTag    (fillTag    ),
        .touchEnable(touchEnable),
        .touchWay   (touchWay   ),
        .busRequest (busRequest ),
        .busAddr    (busAddr    ),
        .busData    (busData    ),
        .busReady   (busReady   ),
        .rspValid   (rspValid   ),
        .rspReady   (rspReady   ),
        .rspData    (rspData    )
    );

    icacheWayMemory wayMemory (
        .clk        (clk        ),
        .reset      (reset      ),
        .invalidate (invalidate ),
        .readSet    (readSet    ),
        .readOffset (readOffset ),
        .writeEnable(writeEnable),
        .writeWay   (writeWay   ),
        .writeOffset(writeOffset),
        .writeData  (writeData  ),
        .markValid  (markValid  ),
        .fillTag    (fillTag    ),
        .touchEnable(touchEnable),
        .touchWay   (touchWay   ),
        .way0Valid  (way0Valid  ),
        .way1Valid  (way1Valid  ),
        .way0Tag    (way0Tag    ),
        .way1Tag    (way1Tag    ),
        .way0Data   (way0Data   ),
        .way1Data   (way1Data   ),
        .lruWay     (lruWay     )
    );

endmodule

// File: filelist.f
design/icachePkg.sv
design/icacheRequestStage.sv
design/icacheWayMemory.sv
design/icacheController.sv
design/instrCache.sv
sim/instrCacheTb.sv

// File: sim/icachePatterns.txt
# F enable addr(hex) physTag(hex) busWords | I invalidate | P rspStall% busStall%
# Set is addr[7:4], word offset is addr[3:2]
P 0 0
# Cold miss on set 1, then hits to every word
F 1 00400010 000101 4
F 1 00400014 000101 0
F 1 0040001C 000101 0
F 1 00400018 000101 0
F 1 00400024 000101 4
F 1 00400020 000101 0
F 1 0040001C 000101 0
# Set 5 with tags A=211 B=322 C=333, A B A C evicts B
F 1 00400058 000211 4
F 1 00400054 000322 4
F 1 0040005C 000211 0
F 1 00400050 000333 4
F 1 00400054 000211 0
F 1 00400058 000322 4
F 1 00400050 000211 0
# Uncached fetches fill nothing
F 0 00400010 000101 1
F 0 00400094 000777 1
F 0 00400098 000777 1
F 1 00400094 000777 4
F 1 00400098 000777 0
# Invalidate drops every resident line
I
F 1 00400014 000101 4
F 1 00400058 000211 4
F 1 0040009C 000777 4
F 1 00400050 000211 0
# Random stalls on the response and the bus
P 30 30
F 1 00400054 000322 4
F 1 00400010 000101 0
F 1 00400100 000505 4
F 1 00400104 000505 0
F 0 004001A0 000505 1
F 1 0040010C 000505 0
F 1 004000E8 000606 4
F 1 004000E4 000606 0
# Back-to-back hits with rspReady held high
P 0 0
F 1 00400100 000505 0
F 1 00400104 000505 0
F 1 00400108 000505 0
F 1 0040010C 000505 0
F 1 00400014 000101 0
F 1 00400058 000211 0
F 1 00400054 000322 0
F 1 004000E0 000606 0
F 1 0040001C 000101 0

// File: sim/instrCacheTb.sv
// ##########################################################
// Testbench for the two-way instruction cache
// Replays fetch patterns against a random bus memory model
// ##########################################################

module instrCacheTb;

    localparam int Timeout = 200;

    // One fetch in flight, oldest first
    typedef struct packed {
        logic            uncached;
        icachePkg::wordT addr;
        icachePkg::tagT  tag;
        icachePkg::wordT data;
        int              busWords;
        int              acceptCycle;
    } fetchT;

    logic            clk;
    logic            reset;
    logic            reqValid;
    logic            reqReady;
    icachePkg::wordT addr;
    icachePkg::tagT  physTag;
    logic            rspValid;
    logic            rspReady;
    icachePkg::wordT rspData;
    logic            busRequest;
    icachePkg::wordT busAddr;
    icachePkg::wordT busData;
    logic            busReady;
    logic            enable;
    logic            invalidate;

    icachePkg::wordT modelMem [4096];
    fetchT           pending [$];
    int              errorCount;
    int              timeoutCount;
    int              fetchCount;
    int              responseCount;
    int              cycle;
    int              busCount;
    int              rspStallPct;
    int              busStallPct;
    int              firstValidCycle;
    logic            headSeen;
    logic            stalledBefore;
    icachePkg::wordT stalledData;
    logic            prevHit;

    instrCache DUT (
        .clk       (clk       ),
        .reset     (reset     ),
        .reqValid  (reqValid  ),
        .reqReady  (reqReady  ),
        .addr      (addr      ),
        .physTag   (physTag   ),
        .rspValid  (rspValid  ),
        .rspReady  (rspReady  ),
        .rspData   (rspData   ),
        .busRequest(busRequest),
        .busAddr   (busAddr   ),
        .busData   (busData   ),
        .busReady  (busReady  ),
        .enable    (enable    ),
        .invalidate(invalidate)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = !clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Bus memory model, bus slave and response sink with random low cycles
    initial begin
        busReady = 1'b0;
        busData  = '0;
        rspReady = 1'b0;
        void'($urandom(32'h4cce28aa));
        for (int i = 0; i < 4096; i++) begin
            modelMem[i] = $urandom;
        end
        forever begin
            @(posedge clk);
            #2;
            busReady = ($urandom % 100) >= busStallPct;
            rspReady = ($urandom % 100) >= rspStallPct;
            busData  = modelMem[busAddr[13:2]];
        end
    end

    // Line base from tag and set, word number from the refill count
    function automatic icachePkg::wordT refillAddress(icachePkg::tagT t, icachePkg::wordT a,
                                                       int n);
        return {t, a[7:4], n[1:0], 2'b00};
    endfunction

    // Uncached words come from the request address, cached ones from the physical line
    function automatic icachePkg::wordT expectedWord(logic uncached, icachePkg::wordT a,
                                                      icachePkg::tagT t);
        if (uncached) begin
            return modelMem[a[13:2]];
        end
        return modelMem[{t[5:0], a[7:4], a[3:2]}];
    endfunction

    task automatic observeBus();
        icachePkg::wordT expectAddr;
        if (busRequest && busReady) begin
            if (pending.size() == 0) begin
                errorCount++;
                $display("Bus transfer at %0t with no fetch outstanding", $time);
            end else begin
                if (pending[0].uncached) begin
                    expectAddr = {pending[0].addr[31:2], 2'b00};
                end else begin
                    expectAddr = refillAddress(pending[0].tag, pending[0].addr, busCount);
                end
                assert (busAddr == expectAddr) else begin
                    errorCount++;
                    $display("** Error at %0t: busAddr %h, expected %h", $time, busAddr,
                             expectAddr);
                end
                busCount++;
            end
        end
    endtask

    task automatic observeResponse();
        fetchT head;
        if (stalledBefore) begin
            assert (rspValid && rspData == stalledData) else begin
                errorCount++;
                $display("** Error at %0t: stalled response changed from %h to %h", $time,
                         stalledData, rspData);
            end
        end
        stalledBefore = rspValid && !rspReady;
        stalledData   = rspData;
        if (rspValid && !headSeen) begin
            headSeen        = 1'b1;
            firstValidCycle = cycle;
        end
        if (rspValid && rspReady) begin
            if (pending.size() == 0) begin
                errorCount++;
                $display("Response at %0t with no fetch outstanding", $time);
            end else begin
                head = pending.pop_front();
                responseCount++;
                assert (rspData == head.data) else begin
                    errorCount++;
                    $display("** Error at %0t: rspData %h, expected %h for addr %h", $time,
                             rspData, head.data, head.addr);
                end
                assert (busCount == head.busWords) else begin
                    errorCount++;
                    $display("** Error at %0t: %0d bus words for addr %h, expected %0d", $time,
                             busCount, head.addr, head.busWords);
                end
                // A hit answers in the cycle after acceptance
                if (!head.uncached && head.busWords == 0) begin
                    assert (firstValidCycle == head.acceptCycle + 1) else begin
                        errorCount++;
                        $display("** Error at %0t: hit on addr %h took %0d cycles", $time,
                                 head.addr, firstValidCycle - head.acceptCycle);
                    end
                end
            end
            busCount = 0;
            headSeen = 1'b0;
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            observeBus();
            observeResponse();
        end
    end

    // Waits until every accepted fetch has been answered
    task automatic drainPipeline();
        int waited;
        waited = 0;
        while (pending.size() != 0 && timeoutCount == 0) begin
            @(posedge clk);
            #2;
            waited++;
            if (pending.size() != 0 && waited >= Timeout) begin
                timeoutCount++;
                $display("Timeout: %0d responses still missing after %0d cycles",
                         pending.size(), Timeout);
            end
        end
    endtask

    task automatic sendFetch(logic en, icachePkg::wordT a, icachePkg::tagT t, int words);
        fetchT item;
        int    waited;
        logic  accepted;
        logic  firstLook;
        // Enable applies to the held request, so it only changes when empty
        if (en != enable) begin
            drainPipeline();
            enable = en;
        end
        reqValid  = 1'b1;
        addr      = a;
        physTag   = t;
        waited    = 0;
        accepted  = 1'b0;
        firstLook = 1'b1;
        while (!accepted && timeoutCount == 0) begin
            @(negedge clk);
            if (firstLook && prevHit && rspStallPct == 0) begin
                assert (reqReady) else begin
                    errorCount++;
                    $display("** Error at %0t: reqReady low during back-to-back hits", $time);
                end
            end
            firstLook = 1'b0;
            if (reqReady) begin
                accepted = 1'b1;
            end else begin
                waited++;
                if (waited >= Timeout) begin
                    timeoutCount++;
                    $display("Timeout: reqReady stayed low for %0d cycles", Timeout);
                end
            end
        end
        if (accepted) begin
            item.uncached    = !en;
            item.addr        = a;
            item.tag         = t;
            item.data        = expectedWord(!en, a, t);
            item.busWords    = words;
            item.acceptCycle = cycle;
            pending.push_back(item);
            fetchCount++;
        end
        @(posedge clk);
        #2;
        reqValid = 1'b0;
        prevHit  = en && (words == 0);
    endtask

    // Only legal while the controller is idle
    task automatic pulseInvalidate();
        drainPipeline();
        invalidate = 1'b1;
        @(posedge clk);
        #2;
        invalidate = 1'b0;
    endtask

    task automatic setStalls(int rspPct, int busPct);
        drainPipeline();
        rspStallPct = rspPct;
        busStallPct = busPct;
    endtask

    initial begin
        int          fd;
        int          fields;
        int          en;
        int          words;
        logic [31:0] a;
        logic [31:0] t;
        byte         cmd;
        string       line;

        reset           = 1'b1;
        reqValid        = 1'b0;
        addr            = '0;
        physTag         = '0;
        enable          = 1'b1;
        invalidate      = 1'b0;
        errorCount      = 0;
        timeoutCount    = 0;
        fetchCount      = 0;
        responseCount   = 0;
        busCount        = 0;
        rspStallPct     = 0;
        busStallPct     = 0;
        firstValidCycle = 0;
        headSeen        = 1'b0;
        stalledBefore   = 1'b0;
        stalledData     = '0;
        prevHit         = 1'b0;

        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        @(negedge clk);
        assert (!rspValid && !busRequest && reqReady) else begin
            errorCount++;
            $display("** Error at %0t: rspValid, busRequest or reqReady wrong after reset",
                     $time);
        end
        @(posedge clk);
        #2;

        fd = $fopen("sim/icachePatterns.txt", "r");
        if (fd == 0) begin
            errorCount++;
            $display("Could not open the pattern file sim/icachePatterns.txt");
        end else begin
            while (!$feof(fd) && timeoutCount == 0) begin
                fields = $fgets(line, fd);
                if (fields > 0 && line.len() > 1) begin
                    cmd = line.getc(0);
                    if (cmd == "F") begin
                        fields = $sscanf(line.substr(1, line.len() - 1), "%d %h %h %d",
                                         en, a, t, words);
                        if (fields == 4) begin
                            sendFetch(en[0], a, t[23:0], words);
                        end else begin
                            errorCount++;
                            $display("Malformed fetch line: %s", line);
                        end
                    end else if (cmd == "I") begin
                        pulseInvalidate();
                    end else if (cmd == "P") begin
                        fields = $sscanf(line.substr(1, line.len() - 1), "%d %d", en, words);
                        setStalls(en, words);
                    end else if (cmd != "#") begin
                        errorCount++;
                        $display("Unknown pattern line: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
        drainPipeline();
        repeat (2) @(posedge clk);

        $display("Fetches %0d, responses %0d, errors %0d, timeouts %0d",
                 fetchCount, responseCount, errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0 && fetchCount > 0 &&
            responseCount == fetchCount) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
